//--- rv_core.f
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/rv_fetch.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_memory.sv
src/rv_core.sv
verif/tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/tb_rv_core.sv
/*
 * Testbench for the five-stage RV32I subset core
 * Random programs from a fixed seed, checked against an in-order ISA model
 */
`default_nettype none

module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int IMEM_WORDS   = 256;
    localparam int NUM_REGS     = 32;
    localparam int DMEM_WORDS   = 32;
    localparam int ALU_LEN      = 48;
    localparam int MIX_LEN      = 64;
    localparam int DRAIN_CYCLES = 8;
    localparam int PAUSE_AT     = 28;  // Enabled cycles before the pause
    localparam int PAUSE_CYCLES = 6;
    localparam int BUDGET_RESET = RESET_CYCLES + NUM_REGS + 2;
    localparam int BUDGET_ALU   = RESET_CYCLES + IMEM_WORDS + ALU_LEN + DRAIN_CYCLES
                                  + PAUSE_CYCLES + NUM_REGS + 4;
    localparam int BUDGET_MIX   = RESET_CYCLES + IMEM_WORDS + 2 * MIX_LEN + DRAIN_CYCLES
                                  + NUM_REGS + 4;
    localparam int WATCHDOG_CYCLES = 2 * (BUDGET_RESET + BUDGET_ALU + BUDGET_MIX) + 100;

    logic        clk = 1'b0;
    logic        i_reset, i_en, i_imem_wen, i_du_rgfile_rd;
    logic [7:0]  i_imem_waddr;
    logic [31:0] i_imem_data;
    logic [4:0]  i_regfile_addr;
    logic [31:0] o_pc, o_regfile_data;

    logic [31:0] model_regs [NUM_REGS];
    logic [31:0] model_mem [DMEM_WORDS];
    logic [31:0] program_words [IMEM_WORDS];
    logic [4:0]  prev_rd;
    logic        last_was_load;
    int          prog_len;
    int          enabled_cycles;
    integer      seed;

    rv_core dut0 (
        .clk, .i_reset, .i_en, .i_imem_wen, .i_imem_waddr, .i_imem_data,
        .i_du_rgfile_rd, .i_regfile_addr, .o_pc, .o_regfile_data
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    // ISA semantics of the ALU instructions with alt selecting sub and sra
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [4:0]         sh;
        sa = a;
        sb = b;
        sh = b[4:0];
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << sh;
            3'b010: return (sa < sb) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return sa >>> sh;
                end
                return a >> sh;
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic write_reg(input logic [4:0] rd, input logic [31:0] value);
        if (rd != 5'd0) begin
            model_regs[rd] = value;  // x0 stays zero
        end
    endtask

    // Generates one instruction, stores its word and runs it on the model
    task automatic gen_instr(input bit allow_mem);
        int          kind;
        logic [4:0]  rd, dep, rs2, off;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm12;
        logic [31:0] word;
        kind  = rand_below(allow_mem ? 5 : 3);
        rd    = (rand_below(8) == 0) ? 5'd0 : 5'(1 + rand_below(15));
        dep   = (last_was_load || rand_below(2) == 0) ? prev_rd : 5'(rand_below(16));
        rs2   = (rand_below(2) == 0) ? prev_rd : 5'(rand_below(16));
        f3    = 3'(rand_below(8));
        alt   = 1'b0;
        imm12 = 12'(rand_below(4096));
        off   = 5'(rand_below(DMEM_WORDS));
        case (kind)
            0: begin  // Register-register
                if (f3 == 3'b000 || f3 == 3'b101) begin
                    alt = (rand_below(2) == 1);
                end
                word = {alt ? 7'b0100000 : 7'b0000000, rs2, dep, f3, rd, 7'b0110011};
                write_reg(rd, alu_model(f3, alt, model_regs[dep], model_regs[rs2]));
            end
            1: begin  // Immediate forms with a legal shift field
                if (f3 == 3'b001) begin
                    imm12 = {7'b0000000, imm12[4:0]};
                end else if (f3 == 3'b101) begin
                    alt   = (rand_below(2) == 1);
                    imm12 = {alt ? 7'b0100000 : 7'b0000000, imm12[4:0]};
                end
                word = {imm12, dep, f3, rd, 7'b0010011};
                write_reg(rd, alu_model(f3, alt, model_regs[dep], {{20{imm12[11]}}, imm12}));
            end
            2: begin  // lui
                word = {imm12, imm12[7:0], rd, 7'b0110111};
                write_reg(rd, {imm12, imm12[7:0], 12'b0});
            end
            3: begin  // lw from base x0
                word = {5'b00000, off, 2'b00, 5'd0, 3'b010, rd, 7'b0000011};
                write_reg(rd, model_mem[off]);
            end
            default: begin  // sw to base x0
                word = {5'b00000, off[4:3], dep, 5'd0, 3'b010, off[2:0], 2'b00, 7'b0100011};
                model_mem[off] = model_regs[dep];
            end
        endcase
        program_words[prog_len] = word;
        prog_len++;
        last_was_load = (kind == 3);
        if (kind != 4) begin
            prev_rd = rd;
        end
    endtask

    task automatic build_program(input int len, input bit allow_mem);
        prog_len      = 0;
        prev_rd       = 5'd0;
        last_was_load = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        for (int i = 0; i < len; i++) begin
            gen_instr(allow_mem);
        end
        for (int i = len; i < IMEM_WORDS; i++) begin
            program_words[i] = rv_isa_pkg::NOP_INSTR;
        end
    endtask

    task automatic reset_core();
        @(negedge clk);
        i_reset = 1'b1;
        i_en    = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        i_reset        = 1'b0;
        enabled_cycles = 0;
    endtask

    task automatic load_program();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            @(negedge clk);
            i_imem_wen   = 1'b1;
            i_imem_waddr = 8'(i);
            i_imem_data  = program_words[i];
        end
        @(negedge clk);
        i_imem_wen = 1'b0;
    endtask

    // PC must equal 4 per enabled cycle while no stall can occur
    task automatic run_enabled(input int n, input bit check_pc);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            if (check_pc) begin
                check_equal("pc_count", 32'(4 * enabled_cycles), o_pc);
            end
            i_en = 1'b1;
            enabled_cycles++;
        end
        @(negedge clk);
        i_en = 1'b0;
        if (check_pc) begin
            check_equal("pc_count", 32'(4 * enabled_cycles), o_pc);
        end
    endtask

    task automatic hold_disabled(input int n);
        logic [31:0] held_pc;
        held_pc = o_pc;
        repeat (n) begin
            @(negedge clk);
            check_equal("pc_pause", held_pc, o_pc);
        end
    endtask

    // Each debug read is sampled one period after its address
    task automatic check_registers(input string test_name);
        for (int r = 0; r <= NUM_REGS; r++) begin
            @(negedge clk);
            if (r > 0) begin
                check_equal($sformatf("%s x%0d", test_name, r - 1), model_regs[r - 1],
                            o_regfile_data);
            end
            i_du_rgfile_rd = (r < NUM_REGS);
            i_regfile_addr = 5'(r);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed           = 32'ha903_18aa;
        i_reset        = 1'b1;
        i_en           = 1'b0;
        i_imem_wen     = 1'b0;
        i_imem_waddr   = '0;
        i_imem_data    = '0;
        i_du_rgfile_rd = 1'b0;
        i_regfile_addr = '0;

        build_program(0, 1'b0);  // Empty program with an all-zero model
        reset_core();
        check_equal("reset_pc", 32'd0, o_pc);
        check_registers("reset");

        build_program(ALU_LEN, 1'b0);
        reset_core();
        load_program();
        run_enabled(PAUSE_AT, 1'b1);
        hold_disabled(PAUSE_CYCLES);
        run_enabled(ALU_LEN + DRAIN_CYCLES - PAUSE_AT, 1'b1);
        check_registers("alu");

        // Loads, stores and load-use pairs with x0 targets
        build_program(MIX_LEN, 1'b1);
        reset_core();
        load_program();
        run_enabled(2 * MIX_LEN + DRAIN_CYCLES, 1'b0);
        check_registers("mix");

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/rv_core.sv
/*
 * RV32I subset core, five-stage pipeline
 * Connects fetch, decode with the register file, execute and memory
 */
`default_nettype none

module rv_core #(
    parameter int IMEM_ADDR_WIDTH = 8,
    parameter int DMEM_ADDR_WIDTH = 5
) (
    input  wire logic                       clk,
    input  wire logic                       i_reset,
    input  wire logic                       i_en,
    input  wire logic                       i_imem_wen,
    input  wire logic [IMEM_ADDR_WIDTH-1:0] i_imem_waddr,
    input  rv_isa_pkg::word_t               i_imem_data,
    input  wire logic                       i_du_rgfile_rd,
    input  rv_isa_pkg::reg_addr_t           i_regfile_addr,
    output rv_isa_pkg::word_t               o_pc,
    output rv_isa_pkg::word_t               o_regfile_data
);

    rv_pipe_pkg::if_id_t   if_id;
    rv_pipe_pkg::id_ex_t   id_ex;
    rv_pipe_pkg::ex_mem_t  ex_mem;
    rv_pipe_pkg::mem_wb_t  mem_wb;   // Write-back and second forwarding source
    rv_isa_pkg::reg_addr_t rs1_addr;
    rv_isa_pkg::reg_addr_t rs2_addr;
    rv_isa_pkg::word_t     rs1_data;
    rv_isa_pkg::word_t     rs2_data;
    logic                  stall;

    rv_fetch #(.IMEM_ADDR_WIDTH(IMEM_ADDR_WIDTH)) u_fetch (
        .clk, .i_reset, .i_en, .i_stall(stall), .i_imem_wen, .i_imem_waddr, .i_imem_data,
        .o_pc, .o_if_id(if_id)
    );

    rv_decode u_decode (
        .clk, .i_reset, .i_en, .i_if_id(if_id), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
        .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_stall(stall), .o_id_ex(id_ex)
    );

    rv_regfile u_regfile (
        .clk, .i_reset, .i_en, .i_wb(mem_wb), .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
        .i_du_rgfile_rd, .i_regfile_addr,
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data), .o_regfile_data
    );

    rv_execute u_execute (
        .clk, .i_reset, .i_en, .i_id_ex(id_ex), .i_mem_wb(mem_wb), .o_ex_mem(ex_mem)
    );

    rv_memory #(.DMEM_ADDR_WIDTH(DMEM_ADDR_WIDTH)) u_memory (
        .clk, .i_reset, .i_en, .i_ex_mem(ex_mem), .o_mem_wb(mem_wb)
    );

endmodule

`default_nettype wire

//--- src/rv_memory.sv
/*
 * Memory stage
 * Word data memory, write-back value select and the MEM/WB register
 */
`default_nettype none

module rv_memory #(
    parameter int DMEM_ADDR_WIDTH = 5
) (
    input  wire logic           clk,
    input  wire logic           i_reset,
    input  wire logic           i_en,
    input  rv_pipe_pkg::ex_mem_t i_ex_mem,
    output rv_pipe_pkg::mem_wb_t o_mem_wb
);

    rv_isa_pkg::word_t          dmem [2**DMEM_ADDR_WIDTH];
    logic [DMEM_ADDR_WIDTH-1:0] addr;
    rv_isa_pkg::word_t          load_data;
    rv_pipe_pkg::mem_wb_t       mem_wb_q;

    assign addr      = i_ex_mem.alu_result[DMEM_ADDR_WIDTH+1:2];  // Byte address to word index
    assign load_data = dmem[addr];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < 2**DMEM_ADDR_WIDTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (i_en && i_ex_mem.mem_write) begin
            dmem[addr] <= i_ex_mem.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            mem_wb_q <= '0;
        end else if (i_en) begin
            mem_wb_q.reg_write <= i_ex_mem.reg_write;
            mem_wb_q.rd        <= i_ex_mem.rd;
            mem_wb_q.wb_data   <= i_ex_mem.mem_read ? load_data : i_ex_mem.alu_result;
        end
    end

    assign o_mem_wb = mem_wb_q;

endmodule

`default_nettype wire

//--- src/rv_execute.sv
/*
 * Execute stage
 * Operand forwarding, ALU and the EX/MEM register
 */
`default_nettype none

module rv_execute (
    input  wire logic           clk,
    input  wire logic           i_reset,
    input  wire logic           i_en,
    input  rv_pipe_pkg::id_ex_t  i_id_ex,
    input  rv_pipe_pkg::mem_wb_t i_mem_wb,
    output rv_pipe_pkg::ex_mem_t o_ex_mem
);

    rv_pipe_pkg::ex_mem_t ex_mem_q;
    rv_isa_pkg::word_t    op_a;
    rv_isa_pkg::word_t    rs2_fwd;
    rv_isa_pkg::word_t    op_b;
    rv_isa_pkg::word_t    alu_result;
    logic [4:0]           shamt;

    // EX/MEM holds the younger result and wins over MEM/WB
    function automatic rv_isa_pkg::word_t forward(input rv_isa_pkg::reg_addr_t src,
                                                  input rv_isa_pkg::word_t rf_data,
                                                  input rv_pipe_pkg::ex_mem_t em,
                                                  input rv_pipe_pkg::mem_wb_t mw);
        if (src != '0 && em.reg_write && em.rd == src) begin
            return em.alu_result;
        end else if (src != '0 && mw.reg_write && mw.rd == src) begin
            return mw.wb_data;
        end
        return rf_data;
    endfunction

    always_comb op_a    = forward(i_id_ex.rs1, i_id_ex.rs1_data, ex_mem_q, i_mem_wb);
    always_comb rs2_fwd = forward(i_id_ex.rs2, i_id_ex.rs2_data, ex_mem_q, i_mem_wb);

    assign op_b  = i_id_ex.ctrl.alu_src_imm ? i_id_ex.imm : rs2_fwd;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            rv_isa_pkg::ALU_ADD:    alu_result = op_a + op_b;
            rv_isa_pkg::ALU_SUB:    alu_result = op_a - op_b;
            rv_isa_pkg::ALU_AND:    alu_result = op_a & op_b;
            rv_isa_pkg::ALU_OR:     alu_result = op_a | op_b;
            rv_isa_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
            rv_isa_pkg::ALU_SLT:    alu_result = rv_isa_pkg::word_t'($signed(op_a) < $signed(op_b));
            rv_isa_pkg::ALU_SLTU:   alu_result = rv_isa_pkg::word_t'(op_a < op_b);
            rv_isa_pkg::ALU_SLL:    alu_result = op_a << shamt;
            rv_isa_pkg::ALU_SRL:    alu_result = op_a >> shamt;
            rv_isa_pkg::ALU_SRA:    alu_result = rv_isa_pkg::word_t'($signed(op_a) >>> shamt);
            rv_isa_pkg::ALU_PASS_B: alu_result = op_b;
            default:                alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            ex_mem_q <= '0;
        end else if (i_en) begin
            ex_mem_q.reg_write  <= i_id_ex.ctrl.reg_write;
            ex_mem_q.mem_read   <= i_id_ex.ctrl.mem_read;
            ex_mem_q.mem_write  <= i_id_ex.ctrl.mem_write;
            ex_mem_q.rd         <= i_id_ex.rd;
            ex_mem_q.alu_result <= alu_result;
            ex_mem_q.store_data <= rs2_fwd;  // sw data after forwarding
        end
    end

    assign o_ex_mem = ex_mem_q;

endmodule

`default_nettype wire

//--- src/rv_decode.sv
/*
 * Decode stage
 * Control and immediate generation, load-use hazard detection, ID/EX register
 */
`default_nettype none

module rv_decode (
    input  wire logic             clk,
    input  wire logic             i_reset,
    input  wire logic             i_en,
    input  rv_pipe_pkg::if_id_t   i_if_id,
    input  rv_isa_pkg::word_t     i_rs1_data,
    input  rv_isa_pkg::word_t     i_rs2_data,
    output rv_isa_pkg::reg_addr_t o_rs1_addr,
    output rv_isa_pkg::reg_addr_t o_rs2_addr,
    output logic                  o_stall,
    output rv_pipe_pkg::id_ex_t   o_id_ex
);

    rv_isa_pkg::word_t     instr;
    rv_isa_pkg::opcode_t   opcode;
    rv_isa_pkg::funct3_t   funct3;
    rv_isa_pkg::reg_addr_t rs1;
    rv_isa_pkg::reg_addr_t rs2;
    rv_isa_pkg::reg_addr_t rd;
    logic                  alt;
    logic                  uses_rs1;
    logic                  uses_rs2;
    rv_pipe_pkg::ctrl_t    ctrl;
    rv_isa_pkg::word_t     imm;
    rv_pipe_pkg::id_ex_t   id_ex_d;
    rv_pipe_pkg::id_ex_t   id_ex_q;

    assign instr  = i_if_id.instr;
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign alt    = (instr[31:25] == rv_isa_pkg::F7_ALT);

    // Immediate forms only use alt for srai
    function automatic rv_isa_pkg::alu_op_t alu_decode(input rv_isa_pkg::funct3_t f3,
                                                       input logic alt_f7,
                                                       input logic is_reg);
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: return (alt_f7 && is_reg) ? rv_isa_pkg::ALU_SUB
                                                              : rv_isa_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     return rv_isa_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     return rv_isa_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    return rv_isa_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     return rv_isa_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: return alt_f7 ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      return rv_isa_pkg::ALU_OR;
            default:                return rv_isa_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl     = '0;
        imm      = '0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_decode(funct3, alt, 1'b1);
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_decode(funct3, alt, 1'b0);
                imm              = {{20{instr[31]}}, instr[31:20]};
                uses_rs1         = 1'b1;
            end
            rv_isa_pkg::OPC_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = rv_isa_pkg::ALU_PASS_B;
                imm              = {instr[31:12], 12'b0};
            end
            rv_isa_pkg::OPC_LOAD: begin
                if (funct3 == rv_isa_pkg::F3_LW) begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.mem_read    = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.alu_op      = rv_isa_pkg::ALU_ADD;
                    imm              = {{20{instr[31]}}, instr[31:20]};
                    uses_rs1         = 1'b1;
                end
            end
            rv_isa_pkg::OPC_STORE: begin
                if (funct3 == rv_isa_pkg::F3_SW) begin
                    ctrl.mem_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.alu_op      = rv_isa_pkg::ALU_ADD;
                    imm              = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                    uses_rs1         = 1'b1;
                    uses_rs2         = 1'b1;
                end
            end
            default: ;  // Unsupported opcode decodes as a bubble
        endcase
    end

    // Load in ID/EX feeding the instruction in IF/ID
    assign o_stall = id_ex_q.ctrl.mem_read && (id_ex_q.rd != '0) &&
                     ((uses_rs1 && id_ex_q.rd == rs1) || (uses_rs2 && id_ex_q.rd == rs2));

    assign id_ex_d = '{ctrl: ctrl, rs1_data: i_rs1_data, rs2_data: i_rs2_data,
                       rs1: rs1, rs2: rs2, rd: rd, imm: imm};

    always_ff @(posedge clk) begin
        if (i_reset) begin
            id_ex_q <= '0;
        end else if (i_en) begin
            id_ex_q <= o_stall ? '0 : id_ex_d;
        end
    end

    assign o_rs1_addr = rs1;
    assign o_rs2_addr = rs2;
    assign o_id_ex    = id_ex_q;

    a_stall_one_cycle: assert property (@(posedge clk) disable iff (i_reset)
        (o_stall && i_en) |=> !o_stall);

endmodule

`default_nettype wire

//--- src/rv_regfile.sv
/*
 * Integer register file
 * 31 writable registers, write-through bypass, debug read on the rs1 port
 */
`default_nettype none

module rv_regfile (
    input  wire logic            clk,
    input  wire logic            i_reset,
    input  wire logic            i_en,
    input  rv_pipe_pkg::mem_wb_t i_wb,
    input  rv_isa_pkg::reg_addr_t i_rs1_addr,
    input  rv_isa_pkg::reg_addr_t i_rs2_addr,
    input  wire logic            i_du_rgfile_rd,
    input  rv_isa_pkg::reg_addr_t i_regfile_addr,
    output rv_isa_pkg::word_t    o_rs1_data,
    output rv_isa_pkg::word_t    o_rs2_data,
    output rv_isa_pkg::word_t    o_regfile_data
);

    rv_isa_pkg::word_t     regs [1:31];
    rv_isa_pkg::reg_addr_t rs1_sel;
    logic                  wen;

    assign wen     = i_en & i_wb.reg_write & (i_wb.rd != '0);
    assign rs1_sel = i_du_rgfile_rd ? i_regfile_addr : i_rs1_addr;  // Debug takes over rs1

    function automatic rv_isa_pkg::word_t read_port(input rv_isa_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wen && i_wb.rd == addr) begin
            return i_wb.wb_data;  // Write-through
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[i_wb.rd] <= i_wb.wb_data;
        end
    end

    always_comb o_rs1_data = read_port(rs1_sel);
    always_comb o_rs2_data = read_port(i_rs2_addr);

    assign o_regfile_data = o_rs1_data;

    // x0 reads zero on both read ports
    a_x0_zero: assert property (@(posedge clk) disable iff (i_reset)
        (rs1_sel != '0 || o_rs1_data == '0) && (i_rs2_addr != '0 || o_rs2_data == '0));

endmodule

`default_nettype wire

//--- src/rv_fetch.sv
/*
 * Fetch stage
 * Program counter, instruction memory with its load port, IF/ID register
 */
`default_nettype none

module rv_fetch #(
    parameter int IMEM_ADDR_WIDTH = 8
) (
    input  wire logic                       clk,
    input  wire logic                       i_reset,
    input  wire logic                       i_en,
    input  wire logic                       i_stall,
    input  wire logic                       i_imem_wen,
    input  wire logic [IMEM_ADDR_WIDTH-1:0] i_imem_waddr,
    input  rv_isa_pkg::word_t               i_imem_data,
    output rv_isa_pkg::word_t               o_pc,
    output rv_pipe_pkg::if_id_t             o_if_id
);

    rv_isa_pkg::word_t   imem [2**IMEM_ADDR_WIDTH];
    rv_isa_pkg::word_t   pc_q;
    rv_isa_pkg::word_t   fetched;
    rv_pipe_pkg::if_id_t if_id_q;
    logic                advance;

    assign advance = i_en & ~i_stall;  // Stall holds PC and IF/ID

    // Program load port
    always_ff @(posedge clk) begin
        if (i_imem_wen) begin
            imem[i_imem_waddr] <= i_imem_data;
        end
    end

    assign fetched = imem[pc_q[IMEM_ADDR_WIDTH+1:2]];  // Word index with upper PC bits ignored

    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc_q <= '0;
        end else if (advance) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            if_id_q.pc    <= '0;
            if_id_q.instr <= rv_isa_pkg::NOP_INSTR;
        end else if (advance) begin
            if_id_q.pc    <= pc_q;
            if_id_q.instr <= fetched;
        end
    end

    assign o_pc    = pc_q;
    assign o_if_id = if_id_q;

    a_pc_aligned: assert property (@(posedge clk) disable iff (i_reset) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- src/rv_pipe_pkg.sv
/*
 * Pipeline bundles
 * Control word and the packed structs carried between the five stages
 */
`default_nettype none

package rv_pipe_pkg;

    // All zero is a bubble
    typedef struct packed {
        logic                reg_write;
        logic                mem_read;
        logic                mem_write;
        logic                alu_src_imm;
        rv_isa_pkg::alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        rv_isa_pkg::word_t pc;
        rv_isa_pkg::word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        rv_isa_pkg::word_t     rs1_data;
        rv_isa_pkg::word_t     rs2_data;
        rv_isa_pkg::reg_addr_t rs1;
        rv_isa_pkg::reg_addr_t rs2;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     alu_result;
        rv_isa_pkg::word_t     store_data;  // Forwarded rs2
    } ex_mem_t;

    // Also the register file write port
    typedef struct packed {
        logic                  reg_write;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     wb_data;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- src/rv_isa_pkg.sv
/*
 * RV32I instruction set subset
 * Word and field types, opcodes, funct codes and ALU operation codes
 */
`default_nettype none

package rv_isa_pkg;

    parameter int XLEN = 32;  // Fixed by the ISA

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;
    typedef logic [3:0]      alu_op_t;

    // Major opcodes handled by the core
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_LW      = 3'b010;
    localparam funct3_t F3_SW      = 3'b010;

    localparam funct7_t F7_ALT = 7'b0100000;  // sub and sra

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLT    = 4'd5;
    localparam alu_op_t ALU_SLTU   = 4'd6;
    localparam alu_op_t ALU_SLL    = 4'd7;
    localparam alu_op_t ALU_SRL    = 4'd8;
    localparam alu_op_t ALU_SRA    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;  // lui

    localparam word_t NOP_INSTR = 32'h0000_0013;  // addi x0,x0,0

endpackage

`default_nettype wire
